// ==== sources.f ====
verilog/uop_pkg.sv
verilog/iq_cfg_pkg.sv
verilog/iq_mem_ctrl.sv
verilog/iq_slot_array.sv
verilog/iq_issue_select.sv
verilog/prf_busy_table.sv
verilog/iq_mem_top.sv
sim/clock_gen.sv
sim/iq_mem_chk.sv
sim/tb_iq_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_iq_mem -o tb_iq_mem
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_iq_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== sim/tb_iq_mem.sv ====
//##########################################################
// Memory issue queue testbench
// Cycle table of dispatch, writeback, back-pressure and
// flush steps with expected issue and full outputs
//##########################################################

module tb_iq_mem;
  timeunit 1ns;
  timeprecision 1ps;
  import uop_pkg::*;

  typedef struct packed {
    logic             v;
    mem_op_e          op;
    logic [tag_w-1:0] tag;
    logic [prf_w-1:0] src;
    logic [prf_w-1:0] rd;
  } lane_t;

  typedef struct {
    string            name;
    lane_t            l0;
    lane_t            l1;
    logic [prf_w-1:0] wb;
    logic             exb;
    logic             clr;
    logic             e_iv;
    logic [tag_w-1:0] e_tag;
    logic             e_full;
  } step_t;

  localparam lane_t no_lane = '0;

  logic                        clock, rst_n, clear, wb_valid, ex_busy;
  logic                        iq_full, issue_valid;
  logic [1:0]                  disp_valid, disp_rs1_use, disp_rs2_use;
  mem_op_e [1:0]               disp_op;
  logic [1:0][tag_w-1:0]       disp_tag;
  logic [1:0][prf_w-1:0]       disp_rs1, disp_rs2, disp_rd;
  logic [prf_w-1:0]            wb_rd, issue_rs1, issue_rs2;
  mem_op_e                     issue_op;
  logic [tag_w-1:0]            issue_tag;

  step_t steps[$];
  // Last lane dispatched under each tag
  lane_t dispatched[2**tag_w];
  string tn;
  int    errors, test_err, tests_ok, tests_bad;
  bit    table_ready;

  clock_gen i_clk (.clock, .rst_n);

  iq_mem_top i_dut (
    .clock, .rst_n, .clear, .disp_valid, .disp_op, .disp_tag,
    .disp_rs1, .disp_rs1_use, .disp_rs2, .disp_rs2_use, .disp_rd,
    .wb_valid, .wb_rd, .ex_busy, .iq_full,
    .issue_valid, .issue_op, .issue_tag, .issue_rs1, .issue_rs2
  );

  function automatic lane_t mk(input mem_op_e op, input int tag, input int src, input int rd);
    lane_t l;
    l.v   = 1'b1;
    l.op  = op;
    l.tag = tag_w'(tag);
    l.src = prf_w'(src);
    l.rd  = prf_w'(rd);
    return l;
  endfunction

  task automatic add_step(input lane_t l0, input lane_t l1, input int wb, input bit exb,
                          input bit clr, input bit e_iv, input int e_tag, input bit e_full);
    step_t s;
    s.name   = tn;
    s.l0     = l0;
    s.l1     = l1;
    s.wb     = prf_w'(wb);
    s.exb    = exb;
    s.clr    = clr;
    s.e_iv   = e_iv;
    s.e_tag  = tag_w'(e_tag);
    s.e_full = e_full;
    steps.push_back(s);
  endtask

  task automatic quiet(input int n);
    repeat (n) add_step(no_lane, no_lane, 0, 0, 0, 0, 0, 0);
  endtask

  task automatic issue(input int tag);
    add_step(no_lane, no_lane, 0, 0, 0, 1, tag, 0);
  endtask

  // Issue lands two edges after the dispatch edge, one step of sampling later
  task automatic build_table();
    tn = "oldest_first";
    add_step(mk(MEM_LD, 1, 0, 0), mk(MEM_LD, 2, 0, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 3, 0, 0), mk(MEM_LD, 4, 0, 0), 0, 0, 0, 0, 0, 0);
    quiet(1);
    issue(1);
    issue(2);
    issue(3);
    issue(4);
    tn = "dependency";
    add_step(mk(MEM_LD, 5, 0, 10), mk(MEM_LD, 6, 10, 11), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 7, 0, 12), no_lane, 0, 0, 0, 0, 0, 0);
    quiet(1);
    issue(5);
    add_step(no_lane, no_lane, 10, 0, 0, 1, 7, 0);
    quiet(2);
    issue(6);
    tn = "store_order";
    add_step(mk(MEM_LD, 8, 11, 13), mk(MEM_ST, 9, 0, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 10, 0, 0), no_lane, 0, 0, 0, 0, 0, 0);
    quiet(2);
    add_step(no_lane, no_lane, 11, 0, 0, 1, 10, 0);
    quiet(2);
    issue(8);
    issue(9);
    tn = "back_pressure";
    add_step(mk(MEM_LD, 11, 0, 0), mk(MEM_LD, 12, 0, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 13, 0, 0), no_lane, 0, 1, 0, 0, 0, 0);
    add_step(no_lane, no_lane, 0, 1, 0, 0, 0, 0);
    add_step(no_lane, no_lane, 0, 1, 0, 0, 0, 0);
    quiet(1);
    issue(11);
    issue(12);
    issue(13);
    // Register 12 is still busy from the dependency test
    tn = "full_flag";
    add_step(mk(MEM_LD, 1, 12, 0), mk(MEM_LD, 2, 12, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 3, 12, 0), mk(MEM_LD, 4, 12, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 5, 12, 0), mk(MEM_LD, 6, 12, 0), 0, 0, 0, 0, 0, 0);
    add_step(mk(MEM_LD, 7, 12, 0), no_lane, 0, 0, 0, 0, 0, 0);
    add_step(no_lane, no_lane, 12, 0, 0, 0, 0, 1);
    // Offered while full, so it must never show up
    add_step(mk(MEM_LD, 15, 0, 0), no_lane, 0, 0, 0, 0, 0, 1);
    add_step(no_lane, no_lane, 0, 0, 0, 0, 0, 1);
    for (int t = 1; t <= 7; t++) begin
      issue(t);
    end
    tn = "flush";
    add_step(mk(MEM_LD, 8, 0, 20), mk(MEM_LD, 9, 20, 21), 0, 0, 0, 0, 0, 0);
    add_step(no_lane, no_lane, 0, 0, 1, 0, 0, 0);
    add_step(mk(MEM_LD, 10, 20, 0), no_lane, 0, 0, 0, 0, 0, 0);
    quiet(2);
    issue(10);
    quiet(1);
  endtask

  task automatic drive_lane(input int i, input lane_t l);
    disp_valid[i]   = l.v;
    disp_op[i]      = l.op;
    disp_tag[i]     = l.tag;
    disp_rs1[i]     = l.src;
    disp_rs1_use[i] = (l.src != '0);
    // Unused second source carries junk that must read as x0
    disp_rs2[i]     = l.rd;
    disp_rs2_use[i] = 1'b0;
    disp_rd[i]      = l.rd;
  endtask

  task automatic apply_step(input step_t s);
    drive_lane(0, s.l0);
    drive_lane(1, s.l1);
    if (s.l0.v) begin
      dispatched[s.l0.tag] = s.l0;
    end
    if (s.l1.v) begin
      dispatched[s.l1.tag] = s.l1;
    end
    wb_valid = (s.wb != '0);
    wb_rd    = s.wb;
    ex_busy  = s.exb;
    clear    = s.clr;
  endtask

  task automatic check_val(input string name, input string what,
                           input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("MISMATCH %s %s: expected %0d, actual %0d", name, what, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic check_step(input step_t s);
    check_val(s.name, "issue_valid", 32'(s.e_iv), 32'(issue_valid));
    check_val(s.name, "iq_full", 32'(s.e_full), 32'(iq_full));
    if (s.e_iv) begin
      check_val(s.name, "issue_tag", 32'(s.e_tag), 32'(issue_tag));
      check_val(s.name, "issue_op", 32'(dispatched[s.e_tag].op), 32'(issue_op));
      check_val(s.name, "issue_rs1", 32'(dispatched[s.e_tag].src), 32'(issue_rs1));
      check_val(s.name, "issue_rs2", 32'(0), 32'(issue_rs2));
    end
  endtask

  task automatic report_test(input string name);
    if (test_err == 0) begin
      tests_ok++;
      $display("test %s: passed", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d mismatches", name, test_err);
    end
    test_err = 0;
  endtask

  initial begin
    drive_lane(0, no_lane);
    drive_lane(1, no_lane);
    wb_valid = 1'b0;
    wb_rd    = '0;
    ex_busy  = 1'b0;
    clear    = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n === 1'b1);
    @(posedge clock);
    for (int i = 0; i < steps.size(); i++) begin
      #1;
      apply_step(steps[i]);
      #8;
      check_step(steps[i]);
      if (i == steps.size() - 1 || steps[i+1].name != steps[i].name) begin
        report_test(steps[i].name);
      end
      @(posedge clock);
    end
    $display("tests passed %0d, failed %0d, mismatches %0d", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized from the table plus the reset cycles
  initial begin
    wait (table_ready);
    #((steps.size() + 5) * 10 + 100);
    $display("timeout: the step table did not finish in time");
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== sim/iq_mem_chk.sv ====
//##########################################################
// Bound assertions for the memory issue queue
// Back-pressure, full flag after flush, store pick position
//##########################################################

module iq_mem_chk (
  input logic                                   clock,
  input logic                                   rst_n,
  input logic                                   clear,
  input logic                                   ex_busy,
  input logic                                   issue_valid,
  input logic                                   iq_full,
  input logic                                   pick_valid,
  input logic [iq_cfg_pkg::slot_idx_w-1:0]      pick_idx,
  input logic [iq_cfg_pkg::iq_size-1:0]         slot_store
);
  timeunit 1ns;
  timeprecision 1ps;

  // Execution busy blocks the pick, so nothing issues next cycle
  assert property (@(posedge clock) disable iff (!rst_n) ex_busy |=> !issue_valid)
    else $error("issue_valid followed a cycle with ex_busy high");

  assert property (@(posedge clock) $rose(rst_n) |-> !iq_full)
    else $error("iq_full high right after reset");

  assert property (@(posedge clock) disable iff (!rst_n) clear |=> !iq_full)
    else $error("iq_full high right after clear");

  // Stores leave only from the head
  assert property (@(posedge clock) disable iff (!rst_n)
    (pick_valid && slot_store[pick_idx]) |-> (pick_idx == '0))
    else $error("store picked outside slot 0");

endmodule

bind iq_mem_top iq_mem_chk i_chk (
  .clock, .rst_n, .clear, .ex_busy, .issue_valid, .iq_full,
  .pick_valid, .pick_idx, .slot_store
);

// ==== sim/clock_gen.sv ====
//##########################################################
// Testbench clock and reset
// 10 ns clock, reset held low for five cycles
//##########################################################

module clock_gen (
  output logic clock,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clock);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== verilog/iq_mem_top.sv ====
//##########################################################
// Memory issue queue top level
// Controller, slot array, picker and busy table
//##########################################################

module iq_mem_top (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_valid,
  input  uop_pkg::mem_op_e [iq_cfg_pkg::disp_w-1:0] disp_op,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::tag_w-1:0] disp_tag,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rs1,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_rs1_use,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rs2,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_rs2_use,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rd,
  input  logic                                   wb_valid,
  input  logic [uop_pkg::prf_w-1:0]              wb_rd,
  input  logic                                   ex_busy,
  output logic                                   iq_full,
  output logic                                   issue_valid,
  output uop_pkg::mem_op_e                       issue_op,
  output logic [uop_pkg::tag_w-1:0]              issue_tag,
  output logic [uop_pkg::prf_w-1:0]              issue_rs1,
  output logic [uop_pkg::prf_w-1:0]              issue_rs2
);
  import uop_pkg::*;
  import iq_cfg_pkg::*;

  logic [iq_size-1:0]                          slot_load, shift_off, slot_clear;
  logic [iq_size-1:0][$clog2(disp_w)-1:0]      lane_sel;
  logic [iq_size-1:0]                          slot_valid, slot_ready, slot_store;
  mem_op_e [iq_size-1:0]                       slot_op;
  logic [iq_size-1:0][tag_w-1:0]               slot_tag;
  logic [iq_size-1:0][prf_w-1:0]               slot_rs1, slot_rs2;
  logic [iq_size-1:0][prf_w-1:0]               rs1_idx, rs2_idx;
  logic [iq_size-1:0]                          rs1_busy, rs2_busy;
  logic                                        pick_valid;
  logic [slot_idx_w-1:0]                       pick_idx;

  iq_mem_ctrl i_ctrl (
    .clock, .rst_n, .clear, .disp_valid, .pick_valid, .pick_idx,
    .slot_load, .lane_sel, .shift_off, .slot_clear, .iq_full
  );

  iq_slot_array i_slots (
    .clock, .rst_n, .slot_load, .lane_sel, .shift_off, .slot_clear,
    .disp_op, .disp_tag, .disp_rs1, .disp_rs1_use, .disp_rs2, .disp_rs2_use,
    .rs1_busy, .rs2_busy, .rs1_idx, .rs2_idx,
    .slot_valid, .slot_ready, .slot_store,
    .slot_op, .slot_tag, .slot_rs1, .slot_rs2
  );

  iq_issue_select i_pick (
    .clock, .rst_n, .clear, .ex_busy,
    .slot_ready, .slot_store, .slot_op, .slot_tag, .slot_rs1, .slot_rs2,
    .pick_valid, .pick_idx,
    .issue_valid, .issue_op, .issue_tag, .issue_rs1, .issue_rs2
  );

  prf_busy_table i_busy (
    .clock, .rst_n, .clear, .disp_valid, .disp_rd,
    .disp_accept (~iq_full),
    .wb_valid, .wb_rd, .rs1_idx, .rs2_idx, .rs1_busy, .rs2_busy
  );

endmodule

// ==== verilog/prf_busy_table.sv ====
//##########################################################
// Physical register busy table
// Set by dispatch destinations, cleared by writeback,
// read per slot for both sources
//##########################################################

module prf_busy_table (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_valid,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rd,
  input  logic                                   disp_accept,
  input  logic                                   wb_valid,
  input  logic [uop_pkg::prf_w-1:0]              wb_rd,
  input  logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] rs1_idx,
  input  logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] rs2_idx,
  output logic [iq_cfg_pkg::iq_size-1:0]         rs1_busy,
  output logic [iq_cfg_pkg::iq_size-1:0]         rs2_busy
);
  import uop_pkg::*;
  import iq_cfg_pkg::*;

  logic [2**prf_w-1:0] busy_q, busy_nxt;

  always_comb begin
    busy_nxt = busy_q;
    for (int i = 0; i < disp_w; i++) begin
      if (disp_valid[i] && disp_accept) begin
        busy_nxt[disp_rd[i]] = 1'b1;
      end
    end
    // Writeback applied last so it beats a same-cycle set
    if (wb_valid) begin
      busy_nxt[wb_rd] = 1'b0;
    end
    busy_nxt[0] = 1'b0;
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (clear) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_nxt;
    end
  end

  for (genvar k = 0; k < iq_size; k++) begin : g_port
    assign rs1_busy[k] = busy_q[rs1_idx[k]];
    assign rs2_busy[k] = busy_q[rs2_idx[k]];
  end

endmodule

// ==== verilog/iq_issue_select.sv ====
//##########################################################
// Memory issue picker
// Oldest ready slot wins, stores only from the head,
// selected micro-op is registered onto the issue port
//##########################################################

module iq_issue_select (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic                                   ex_busy,
  input  logic [iq_cfg_pkg::iq_size-1:0]         slot_ready,
  input  logic [iq_cfg_pkg::iq_size-1:0]         slot_store,
  input  uop_pkg::mem_op_e [iq_cfg_pkg::iq_size-1:0] slot_op,
  input  logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::tag_w-1:0] slot_tag,
  input  logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] slot_rs1,
  input  logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] slot_rs2,
  output logic                                   pick_valid,
  output logic [iq_cfg_pkg::slot_idx_w-1:0]      pick_idx,
  output logic                                   issue_valid,
  output uop_pkg::mem_op_e                       issue_op,
  output logic [uop_pkg::tag_w-1:0]              issue_tag,
  output logic [uop_pkg::prf_w-1:0]              issue_rs1,
  output logic [uop_pkg::prf_w-1:0]              issue_rs2
);
  import uop_pkg::*;
  import iq_cfg_pkg::*;

  logic [iq_size-1:0] cand;

  // A store must be the oldest entry before it may go
  always_comb begin
    cand = slot_ready;
    for (int k = issue_w; k < iq_size; k++) begin
      if (slot_store[k]) begin
        cand[k] = 1'b0;
      end
    end
  end

  always_comb begin
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int k = iq_size - 1; k >= 0; k--) begin
      if (cand[k] && !ex_busy) begin
        pick_valid = 1'b1;
        pick_idx   = slot_idx_w'(k);
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
    end else if (clear) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= pick_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (pick_valid) begin
      issue_op  <= slot_op[pick_idx];
      issue_tag <= slot_tag[pick_idx];
      issue_rs1 <= slot_rs1[pick_idx];
      issue_rs2 <= slot_rs2[pick_idx];
    end
  end

endmodule

// ==== verilog/iq_slot_array.sv ====
//##########################################################
// Memory issue queue slot array
// Eight slots that load, compact downward or hold, and
// report readiness from the busy table lookups
//##########################################################

module iq_slot_array (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic [iq_cfg_pkg::iq_size-1:0]         slot_load,
  input  logic [iq_cfg_pkg::iq_size-1:0][$clog2(iq_cfg_pkg::disp_w)-1:0] lane_sel,
  input  logic [iq_cfg_pkg::iq_size-1:0]         shift_off,
  input  logic [iq_cfg_pkg::iq_size-1:0]         slot_clear,
  input  uop_pkg::mem_op_e [iq_cfg_pkg::disp_w-1:0] disp_op,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::tag_w-1:0] disp_tag,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rs1,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_rs1_use,
  input  logic [iq_cfg_pkg::disp_w-1:0][uop_pkg::prf_w-1:0] disp_rs2,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_rs2_use,
  input  logic [iq_cfg_pkg::iq_size-1:0]         rs1_busy,
  input  logic [iq_cfg_pkg::iq_size-1:0]         rs2_busy,
  output logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] rs1_idx,
  output logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] rs2_idx,
  output logic [iq_cfg_pkg::iq_size-1:0]         slot_valid,
  output logic [iq_cfg_pkg::iq_size-1:0]         slot_ready,
  output logic [iq_cfg_pkg::iq_size-1:0]         slot_store,
  output uop_pkg::mem_op_e [iq_cfg_pkg::iq_size-1:0] slot_op,
  output logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::tag_w-1:0] slot_tag,
  output logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] slot_rs1,
  output logic [iq_cfg_pkg::iq_size-1:0][uop_pkg::prf_w-1:0] slot_rs2
);
  import uop_pkg::*;
  import iq_cfg_pkg::*;

  for (genvar k = 0; k < iq_size; k++) begin : g_slot
    logic             valid_q, new_q, rdy1_q, rdy2_q;
    mem_op_e          op_q;
    logic [tag_w-1:0] tag_q;
    logic [prf_w-1:0] rs1_q, rs2_q;
    logic             up_valid, nxt_valid;
    mem_op_e          up_op, nxt_op;
    logic [tag_w-1:0] up_tag, nxt_tag;
    logic [prf_w-1:0] up_rs1, up_rs2, nxt_rs1, nxt_rs2;

    // Top slot compacts from an empty neighbour
    if (k == iq_size - 1) begin : g_top
      assign up_valid = 1'b0;
      assign up_op    = MEM_LD;
      assign up_tag   = '0;
      assign up_rs1   = '0;
      assign up_rs2   = '0;
    end else begin : g_up
      assign up_valid = slot_valid[k+1];
      assign up_op    = slot_op[k+1];
      assign up_tag   = slot_tag[k+1];
      assign up_rs1   = slot_rs1[k+1];
      assign up_rs2   = slot_rs2[k+1];
    end

    always_comb begin
      if (slot_load[k]) begin
        nxt_valid = 1'b1;
        nxt_op    = disp_op[lane_sel[k]];
        nxt_tag   = disp_tag[lane_sel[k]];
        // Unused source reads as x0, which is never busy
        nxt_rs1   = disp_rs1_use[lane_sel[k]] ? disp_rs1[lane_sel[k]] : '0;
        nxt_rs2   = disp_rs2_use[lane_sel[k]] ? disp_rs2[lane_sel[k]] : '0;
      end else if (shift_off[k]) begin
        nxt_valid = up_valid;
        nxt_op    = up_op;
        nxt_tag   = up_tag;
        nxt_rs1   = up_rs1;
        nxt_rs2   = up_rs2;
      end else begin
        nxt_valid = valid_q;
        nxt_op    = op_q;
        nxt_tag   = tag_q;
        nxt_rs1   = rs1_q;
        nxt_rs2   = rs2_q;
      end
    end

    // Lookup follows the entry this slot holds after the edge
    assign rs1_idx[k] = nxt_rs1;
    assign rs2_idx[k] = nxt_rs2;

    always_ff @(posedge clock or negedge rst_n) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
        new_q   <= 1'b0;
        rdy1_q  <= 1'b0;
        rdy2_q  <= 1'b0;
      end else if (slot_clear[k]) begin
        valid_q <= 1'b0;
        new_q   <= 1'b0;
        rdy1_q  <= 1'b0;
        rdy2_q  <= 1'b0;
      end else begin
        valid_q <= nxt_valid;
        new_q   <= slot_load[k];
        rdy1_q  <= ~rs1_busy[k];
        rdy2_q  <= ~rs2_busy[k];
      end
    end

    always_ff @(posedge clock) begin
      op_q  <= nxt_op;
      tag_q <= nxt_tag;
      rs1_q <= nxt_rs1;
      rs2_q <= nxt_rs2;
    end

    assign slot_valid[k] = valid_q;
    assign slot_op[k]    = op_q;
    assign slot_tag[k]   = tag_q;
    assign slot_rs1[k]   = rs1_q;
    assign slot_rs2[k]   = rs2_q;
    assign slot_store[k] = valid_q && (op_q == MEM_ST);
    // Freshly loaded entries sit out one cycle
    assign slot_ready[k] = valid_q && !new_q && rdy1_q && rdy2_q;
  end

endmodule

// ==== verilog/iq_mem_ctrl.sv ====
//##########################################################
// Memory issue queue controller
// Tracks tail and free count, places dispatch lanes into
// compacted slots, drives shift and clear, flags full
//##########################################################

module iq_mem_ctrl (
  input  logic                                   clock,
  input  logic                                   rst_n,
  input  logic                                   clear,
  input  logic [iq_cfg_pkg::disp_w-1:0]          disp_valid,
  input  logic                                   pick_valid,
  input  logic [iq_cfg_pkg::slot_idx_w-1:0]      pick_idx,
  output logic [iq_cfg_pkg::iq_size-1:0]         slot_load,
  output logic [iq_cfg_pkg::iq_size-1:0][$clog2(iq_cfg_pkg::disp_w)-1:0] lane_sel,
  output logic [iq_cfg_pkg::iq_size-1:0]         shift_off,
  output logic [iq_cfg_pkg::iq_size-1:0]         slot_clear,
  output logic                                   iq_full
);
  import iq_cfg_pkg::*;

  logic [count_w-1:0]             tail_q, free_q;
  logic [count_w-1:0]             tail_nxt, free_nxt;
  logic [count_w-1:0]             pick_cnt, in_cnt, base;
  logic [disp_w-1:0]              accept;
  logic [disp_w-1:0][count_w-1:0] lane_pos;

  // Lanes offered while full are dropped
  assign accept   = disp_valid & {disp_w{~iq_full}};
  assign pick_cnt = pick_valid ? count_w'(1) : '0;

  // New entries land below the slot vacated by this cycle's pick
  assign base = tail_q - pick_cnt;

  always_comb begin
    in_cnt = '0;
    for (int i = 0; i < disp_w; i++) begin
      lane_pos[i] = base + in_cnt;
      if (accept[i]) begin
        in_cnt = in_cnt + count_w'(1);
      end
    end
  end

  assign tail_nxt = base + in_cnt;
  assign free_nxt = free_q + pick_cnt - in_cnt;

  always_comb begin
    slot_load = '0;
    lane_sel  = '0;
    for (int k = 0; k < iq_size; k++) begin
      shift_off[k]  = pick_valid && (slot_idx_w'(k) >= pick_idx);
      slot_clear[k] = clear || (count_w'(k) >= tail_nxt);
      for (int i = 0; i < disp_w; i++) begin
        if (accept[i] && (lane_pos[i] == count_w'(k))) begin
          slot_load[k] = 1'b1;
          lane_sel[k]  = ($clog2(disp_w))'(i);
        end
      end
    end
  end

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      tail_q  <= '0;
      free_q  <= count_w'(iq_size);
      iq_full <= 1'b0;
    end else if (clear) begin
      tail_q  <= '0;
      free_q  <= count_w'(iq_size);
      iq_full <= 1'b0;
    end else begin
      tail_q  <= tail_nxt;
      free_q  <= free_nxt;
      iq_full <= free_nxt < count_w'(disp_w);
    end
  end

endmodule

// ==== verilog/iq_cfg_pkg.sv ====
//##########################################################
// Memory issue queue geometry
// Slot count, lane counts and counter widths
//##########################################################

package iq_cfg_pkg;

  localparam int iq_size = 8;

  // Dispatch lanes in, issue lanes out
  localparam int disp_w = 2;
  localparam int issue_w = 1;

  localparam int slot_idx_w = 3;

  // Occupancy counter must hold the value iq_size
  localparam int count_w = 4;

endpackage

// ==== verilog/uop_pkg.sv ====
//##########################################################
// Micro-op definitions shared by the memory issue queue
// Register index width, reorder tag width, memory opcode
//##########################################################

package uop_pkg;

  // Physical register index
  localparam int prf_w = 5;

  // Reorder tag carried with each micro-op
  localparam int tag_w = 4;

  // Memory opcode
  typedef enum logic {
    MEM_LD = 1'b0,
    MEM_ST = 1'b1
  } mem_op_e;

endpackage
